/* filelist.f */
+incdir+common
common/eval_pkg.sv
logic/latency_counter.sv
logic/eval_sequencer.sv
evaluate/evaluate_general.sv
evaluate/material_tally.sv
logic/chess_eval_top.sv
sim/tb_chess_eval.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the chess evaluator testbench with Verilator.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
   --top-module tb_chess_eval -Mdir obj_dir -o tb_chess_eval
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/tb_chess_eval > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
   exit 0
fi
echo "Pass line not found in $LOG"
exit 1

/* sim/tb_chess_eval.sv */
`timescale 1ns/1ps
`include "eval_params.svh"

module tb_chess_eval import eval_pkg::*;
();

   localparam int WAIT_LIMIT  = 20;
   localparam int CYCLE_LIMIT = 200 * 12 + 200;   // Evaluations times cycles each, plus margin.

   logic         clk;
   logic         rst_n;
   logic         board_valid;
   board_t       board;
   logic         white_to_move;
   logic         use_random_bit;
   logic         random_bit;
   logic         clear_eval;
   logic         eval_valid;
   eval_result_t result;

   int seed;
   int cycle_count = 0;
   int checks      = 0;
   int errors      = 0;
   int test_checks;
   int test_errors;
   int tests_run   = 0;

   chess_eval_top chess_eval_top_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .board_valid    (board_valid),
      .board          (board),
      .white_to_move  (white_to_move),
      .use_random_bit (use_random_bit),
      .random_bit     (random_bit),
      .clear_eval     (clear_eval),
      .eval_valid     (eval_valid),
      .result         (result)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk)
      cycle_count <= cycle_count + 1;

   initial
   begin
      wait (cycle_count >= CYCLE_LIMIT);
      $display("Timeout: run still going after %0d cycles", cycle_count);
      $display("RESULT: FAIL");
      $finish;
   end

   function automatic int piece_worth(input int kind);
      case (kind)
         1:       return `VALUE_PAWN;
         2:       return `VALUE_KNIGHT;
         3:       return `VALUE_BISHOP;
         4:       return `VALUE_ROOK;
         5:       return `VALUE_QUEEN;
         default: return 0;          // King and unused codes.
      endcase
   endfunction

   // Reference evaluation straight from the scoring rules.
   function automatic eval_result_t expected_result(input board_t b, input bit wtm,
         input bit use_rnd, input bit rbit);
      eval_result_t res;
      logic [3:0]   code;
      int           kind;
      int           rank;
      int           file;
      int           mg_sq;
      int           eg_sq;
      int           mg;
      int           eg;
      int           mat[2];
      int           cls[2];
      int           tie;
      mg  = 0;
      eg  = 0;
      mat = '{0, 0};
      cls = '{0, 0};
      for (int sq = 0; sq < `BOARD_SQUARES; sq++)
      begin
         code  = b[sq];
         kind  = int'(code[2:0]);
         rank  = sq / 8;
         file  = sq % 8;
         mg_sq = piece_worth(kind);
         eg_sq = piece_worth(kind);
         if (kind >= 1 && kind <= 3 && rank >= 2 && rank <= 5 && file >= 2 && file <= 5)
            mg_sq = mg_sq + 10;
         if (kind == 1)
            eg_sq = eg_sq + 5 * (code[3] ? 6 - rank : rank - 1);
         mg = code[3] ? mg - mg_sq : mg + mg_sq;
         eg = code[3] ? eg - eg_sq : eg + eg_sq;
         mat[code[3]] = mat[code[3]] + piece_worth(kind);
         if (kind == 1 || kind == 4 || kind == 5)
            cls[code[3]] = cls[code[3]] + 3;
         else if (kind == 2 || kind == 3)
            cls[code[3]] = cls[code[3]] + 1;
      end
      tie = !use_rnd ? 0 : (wtm ? int'(rbit) : -int'(rbit));
      res.eval_mg               = `EVAL_WIDTH'(mg + tie);
      res.eval_eg               = `EVAL_WIDTH'(eg + tie);
      res.material_white        = `MATERIAL_WIDTH'(mat[0]);
      res.material_black        = `MATERIAL_WIDTH'(mat[1]);
      res.insufficient_material = (cls[0] == 0 && cls[1] <= 1) || (cls[1] == 0 && cls[0] <= 1);
      return res;
   endfunction

   function automatic board_t empty_board();
      board_t b;
      for (int sq = 0; sq < `BOARD_SQUARES; sq++)
         b[sq] = EMPTY;
      return b;
   endfunction

   // Codes 0 to 6 and 9 to 14 only.
   task automatic random_board(output board_t b);
      int idx;
      for (int sq = 0; sq < `BOARD_SQUARES; sq++)
      begin
         idx   = $unsigned($random(seed)) % 13;
         b[sq] = piece_e'(idx < 7 ? idx : idx + 2);
      end
   endtask

   task automatic begin_test();
      test_checks = checks;
      test_errors = errors;
   endtask

   task automatic end_test(input string name);
      tests_run++;
      $display("Test %0d %s: %0d checks, %0d errors", tests_run, name,
               checks - test_checks, errors - test_errors);
   endtask

   task automatic check_field(input string name, input logic [15:0] expected,
         input logic [15:0] actual);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("[FAIL] %s: expected %h, got %h", name, expected, actual);
      end
   endtask

   task automatic expect_quiet(input int cycles);
      repeat (cycles)
      begin
         @(negedge clk);
         checks++;
         if (eval_valid !== 1'b0)
         begin
            errors++;
            $display("eval_valid was not low while no result was due");
         end
      end
   endtask

   task automatic send_board(input board_t b, input bit wtm, input bit use_rnd, input bit rbit);
      @(negedge clk);
      board          = b;
      white_to_move  = wtm;
      use_random_bit = use_rnd;
      random_bit     = rbit;
      board_valid    = 1'b1;
      @(negedge clk);
      board_valid = 1'b0;
   endtask

   // Cycles from the board_valid cycle to the pulse, 0 if none came.
   task automatic wait_for_valid(output int cycles);
      int waited;
      waited = 1;
      while (eval_valid !== 1'b1 && waited < WAIT_LIMIT)
      begin
         @(negedge clk);
         waited++;
      end
      cycles = (eval_valid === 1'b1) ? waited : 0;
   endtask

   task automatic evaluate_board(input board_t b, input bit wtm, input bit use_rnd,
         input bit rbit);
      eval_result_t expected;
      int           cycles;
      expected = expected_result(b, wtm, use_rnd, rbit);
      send_board(b, wtm, use_rnd, rbit);
      wait_for_valid(cycles);
      checks++;
      if (cycles == 0)
      begin
         errors++;
         $display("No eval_valid pulse within %0d cycles of board_valid", WAIT_LIMIT);
      end
      else
      begin
         if (cycles != `EVAL_LATENCY)
         begin
            errors++;
            $display("eval_valid came %0d cycles after board_valid instead of %0d",
                     cycles, `EVAL_LATENCY);
         end
         check_field("eval_mg", expected.eval_mg, result.eval_mg);
         check_field("eval_eg", expected.eval_eg, result.eval_eg);
         check_field("material_white", expected.material_white, result.material_white);
         check_field("material_black", expected.material_black, result.material_black);
         check_field("insufficient_material", {15'h0, expected.insufficient_material},
                     {15'h0, result.insufficient_material});
         @(negedge clk);
         checks++;
         if (eval_valid !== 1'b0)
         begin
            errors++;
            $display("eval_valid stayed high for a second cycle");
         end
      end
   endtask

   initial
   begin
      board_t b;
      int     r;
      seed           = 12685;
      rst_n          = 1'b0;
      board_valid    = 1'b0;
      board          = empty_board();
      white_to_move  = 1'b1;
      use_random_bit = 1'b0;
      random_bit     = 1'b0;
      clear_eval     = 1'b0;

      begin_test();
      expect_quiet(3);
      rst_n = 1'b1;
      expect_quiet(4);
      end_test("reset");

      begin_test();
      random_board(b);
      evaluate_board(b, 1'b1, 1'b0, 1'b0);
      expect_quiet(5);
      end_test("latency");

      begin_test();
      for (int n = 0; n < 150; n++)
      begin
         random_board(b);
         evaluate_board(b, 1'b1, 1'b0, 1'b0);
      end
      end_test("random boards");

      begin_test();
      b     = empty_board();
      b[4]  = WHITE_KING;
      b[60] = BLACK_KING;
      evaluate_board(b, 1'b1, 1'b0, 1'b0);   // Bare kings.
      b[2] = WHITE_BISHOP;
      evaluate_board(b, 1'b1, 1'b0, 1'b0);
      b[2]  = EMPTY;
      b[12] = WHITE_PAWN;
      evaluate_board(b, 1'b1, 1'b0, 1'b0);
      b[12] = EMPTY;
      b[57] = BLACK_KNIGHT;
      b[62] = BLACK_KNIGHT;
      evaluate_board(b, 1'b0, 1'b0, 1'b0);
      end_test("insufficient material");

      begin_test();
      for (int n = 0; n < 40; n++)
      begin
         random_board(b);
         r = $random(seed);
         evaluate_board(b, r[0], 1'b1, r[1]);
      end
      end_test("random tie-break");

      begin_test();
      random_board(b);
      send_board(b, 1'b1, 1'b0, 1'b0);
      repeat (2) @(negedge clk);
      clear_eval = 1'b1;                     // Three cycles after board_valid.
      @(negedge clk);
      clear_eval = 1'b0;
      expect_quiet(10);
      send_board(b, 1'b1, 1'b0, 1'b0);
      @(negedge clk);
      random_board(b);
      evaluate_board(b, 1'b1, 1'b0, 1'b0);   // Second board restarts the count.
      end_test("clear and restart");

      $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
      if (errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

/* logic/chess_eval_top.sv */
`timescale 1ns/1ps
`include "eval_params.svh"

module chess_eval_top import eval_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n,
   input  logic         board_valid,
   input  board_t       board,
   input  logic         white_to_move,
   input  logic         use_random_bit,
   input  logic         random_bit,
   input  logic         clear_eval,
   output logic         eval_valid,
   output eval_result_t result
);

   logic signed [`EVAL_WIDTH-1:0] eval_mg;
   logic signed [`EVAL_WIDTH-1:0] eval_eg;
   logic [`MATERIAL_WIDTH-1:0]    material_white;
   logic [`MATERIAL_WIDTH-1:0]    material_black;
   logic                          insufficient_material;
   logic                          load;
   logic                          expired;

   evaluate_general evaluate_general_i (
      .clk            (clk),
      .board          (board),
      .white_to_move  (white_to_move),
      .use_random_bit (use_random_bit),
      .random_bit     (random_bit),
      .eval_mg        (eval_mg),
      .eval_eg        (eval_eg)
   );

   material_tally material_tally_i (
      .clk                   (clk),
      .board                 (board),
      .material_white        (material_white),
      .material_black        (material_black),
      .insufficient_material (insufficient_material)
   );

   eval_sequencer eval_sequencer_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .board_valid (board_valid),
      .clear_eval  (clear_eval),
      .expired     (expired),
      .load        (load),
      .eval_valid  (eval_valid)
   );

   latency_counter latency_counter_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .load    (load),
      .expired (expired)
   );

   // Field order follows eval_result_t.
   assign result = {eval_mg, eval_eg, material_white, material_black, insufficient_material};

endmodule

/* evaluate/material_tally.sv */
`timescale 1ns/1ps
`include "eval_params.svh"

module material_tally import eval_pkg::*;
(
   input  logic                       clk,
   input  board_t                     board,
   output logic [`MATERIAL_WIDTH-1:0] material_white,
   output logic [`MATERIAL_WIDTH-1:0] material_black,
   output logic                       insufficient_material
);

   localparam int SIDE_W   = 0;
   localparam int SIDE_B   = 1;
   localparam int GROUPS_A = `BOARD_SQUARES / 4;
   localparam int GROUPS_B = GROUPS_A / 4;

   logic [`MATERIAL_WIDTH-1:0]       mat_t1 [2][`BOARD_SQUARES];
   logic [`MATERIAL_WIDTH-1:0]       mat_t2 [2][GROUPS_A];
   logic [`MATERIAL_WIDTH-1:0]       mat_t3 [2][GROUPS_B];
   logic [1:0][`MATERIAL_WIDTH-1:0]  mat_t4;
   logic [1:0][`MATERIAL_WIDTH-1:0]  mat_t5;
   logic [1:0][`MATERIAL_WIDTH-1:0]  mat_t6;
   logic [1:0][`MATERIAL_WIDTH-1:0]  mat_t7;
   logic [1:0]                       class_t1 [2][`BOARD_SQUARES];
   logic [7:0]                       class_acc [2];
   logic [7:0]                       class_sum_t2 [2];
   logic                             insuff_t3;
   logic [7:4]                       insuff_dly;

   // Heavy material and pawns count 3, minor pieces 1.
   function automatic logic [1:0] piece_class(input piece_e piece);
      case (piece_e'({1'b0, piece[2:0]}))
         WHITE_PAWN, WHITE_ROOK, WHITE_QUEEN: return 2'd3;
         WHITE_KNIGHT, WHITE_BISHOP:          return 2'd1;
         default:                             return 2'd0;
      endcase
   endfunction

   always_comb
   begin
      for (int s = 0; s < 2; s++)
      begin
         class_acc[s] = '0;
         for (int sq = 0; sq < `BOARD_SQUARES; sq++)
            class_acc[s] = class_acc[s] + 8'(class_t1[s][sq]);
      end
   end

   always_ff @(posedge clk)
   begin
      for (int sq = 0; sq < `BOARD_SQUARES; sq++)
      begin
         mat_t1[SIDE_W][sq]   <= board[sq][3] ? '0 : piece_value(board[sq]);
         mat_t1[SIDE_B][sq]   <= board[sq][3] ? piece_value(board[sq]) : '0;
         class_t1[SIDE_W][sq] <= board[sq][3] ? 2'd0 : piece_class(board[sq]);
         class_t1[SIDE_B][sq] <= board[sq][3] ? piece_class(board[sq]) : 2'd0;
      end

      for (int s = 0; s < 2; s++)
      begin
         for (int g = 0; g < GROUPS_A; g++)
            mat_t2[s][g] <= mat_t1[s][4*g]     + mat_t1[s][4*g + 1] +
                            mat_t1[s][4*g + 2] + mat_t1[s][4*g + 3];
         for (int g = 0; g < GROUPS_B; g++)
            mat_t3[s][g] <= mat_t2[s][4*g]     + mat_t2[s][4*g + 1] +
                            mat_t2[s][4*g + 2] + mat_t2[s][4*g + 3];
         mat_t4[s]       <= mat_t3[s][0] + mat_t3[s][1] + mat_t3[s][2] + mat_t3[s][3];
         class_sum_t2[s] <= class_acc[s];
      end
      mat_t5 <= mat_t4;
      mat_t6 <= mat_t5;
      mat_t7 <= mat_t6;

      // Bare king against at most one minor piece.
      insuff_t3  <= (class_sum_t2[SIDE_W] == 8'd0 && class_sum_t2[SIDE_B] <= 8'd1) ||
                    (class_sum_t2[SIDE_B] == 8'd0 && class_sum_t2[SIDE_W] <= 8'd1);
      insuff_dly <= {insuff_dly[6:4], insuff_t3};
   end

   assign material_white        = mat_t7[SIDE_W];
   assign material_black        = mat_t7[SIDE_B];
   assign insufficient_material = insuff_dly[7];

endmodule

/* evaluate/evaluate_general.sv */
`timescale 1ns/1ps
`include "eval_params.svh"

module evaluate_general import eval_pkg::*;
(
   input  logic                          clk,
   input  board_t                        board,
   input  logic                          white_to_move,
   input  logic                          use_random_bit,
   input  logic                          random_bit,
   output logic signed [`EVAL_WIDTH-1:0] eval_mg,
   output logic signed [`EVAL_WIDTH-1:0] eval_eg
);

   localparam int MG       = 0;
   localparam int EG       = 1;
   localparam int GROUPS_A = `BOARD_SQUARES / 4;
   localparam int GROUPS_B = GROUPS_A / 4;

   logic signed [`EVAL_WIDTH-1:0] score_t1 [2][`BOARD_SQUARES];
   logic signed [`EVAL_WIDTH-1:0] sum_a_t2 [2][GROUPS_A];
   logic signed [`EVAL_WIDTH-1:0] sum_a_t3 [2][GROUPS_A];
   logic signed [`EVAL_WIDTH-1:0] sum_b_t4 [2][GROUPS_B];
   logic signed [`EVAL_WIDTH-1:0] sum_b_t5 [2][GROUPS_B];
   logic signed [`EVAL_WIDTH-1:0] total_t6 [2];
   logic signed [`EVAL_WIDTH-1:0] eval_t7  [2];
   logic signed [1:0]             rnd_pipe [1:6];   // Tie-break term, stages 1 to 6.

   // Piece value plus square bonus, negated for black.
   function automatic logic signed [`EVAL_WIDTH-1:0] square_score(input piece_e piece,
         input int sq, input bit endgame);
      piece_e kind;
      int     rank;
      int     file;
      int     score;
      kind  = piece_e'({1'b0, piece[2:0]});
      rank  = sq / 8;
      file  = sq % 8;
      score = int'(piece_value(piece));
      if (!endgame && (kind == WHITE_PAWN || kind == WHITE_KNIGHT || kind == WHITE_BISHOP) &&
          rank >= 2 && rank <= 5 && file >= 2 && file <= 5)
         score = score + 10;                              // Central squares.
      if (endgame && kind == WHITE_PAWN)
         score = score + 5 * (piece[3] ? 6 - rank : rank - 1);   // Pawn advance.
      if (piece[3])
         score = -score;
      return `EVAL_WIDTH'(score);
   endfunction

   always_ff @(posedge clk)
   begin
      for (int sq = 0; sq < `BOARD_SQUARES; sq++)
      begin
         score_t1[MG][sq] <= square_score(board[sq], sq, 1'b0);
         score_t1[EG][sq] <= square_score(board[sq], sq, 1'b1);
      end

      for (int ph = 0; ph < 2; ph++)
      begin
         for (int g = 0; g < GROUPS_A; g++)
            sum_a_t2[ph][g] <= score_t1[ph][4*g]     + score_t1[ph][4*g + 1] +
                               score_t1[ph][4*g + 2] + score_t1[ph][4*g + 3];
         sum_a_t3[ph] <= sum_a_t2[ph];
         for (int g = 0; g < GROUPS_B; g++)
            sum_b_t4[ph][g] <= sum_a_t3[ph][4*g]     + sum_a_t3[ph][4*g + 1] +
                               sum_a_t3[ph][4*g + 2] + sum_a_t3[ph][4*g + 3];
         sum_b_t5[ph] <= sum_b_t4[ph];
         total_t6[ph] <= sum_b_t5[ph][0] + sum_b_t5[ph][1] +
                         sum_b_t5[ph][2] + sum_b_t5[ph][3];
         eval_t7[ph]  <= total_t6[ph] + rnd_pipe[6];
      end

      // +1 or -1 for the side to move.
      if (!use_random_bit)
         rnd_pipe[1] <= 2'sd0;
      else if (white_to_move)
         rnd_pipe[1] <= $signed({1'b0, random_bit});
      else
         rnd_pipe[1] <= -$signed({1'b0, random_bit});
      for (int k = 2; k <= 6; k++)
         rnd_pipe[k] <= rnd_pipe[k-1];   // Aligns with the adder tree.
   end

   assign eval_mg = eval_t7[MG];
   assign eval_eg = eval_t7[EG];

endmodule

/* logic/eval_sequencer.sv */
`timescale 1ns/1ps

module eval_sequencer import eval_pkg::*;
(
   input  logic clk,
   input  logic rst_n,
   input  logic board_valid,
   input  logic clear_eval,
   input  logic expired,
   output logic load,
   output logic eval_valid
);

   seq_state_e state;
   seq_state_e state_next;

   always_comb
   begin
      state_next = state;
      if (clear_eval)
         state_next = S_IDLE;        // Cancel wins over everything.
      else if (board_valid)
         state_next = S_BUSY;        // Newest board restarts the count.
      else
         case (state)
            S_BUSY:
            begin
               if (expired)
                  state_next = S_DONE;
            end
            S_DONE:  state_next = S_IDLE;
            default: state_next = state;
         endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         state <= S_IDLE;
      else
         state <= state_next;
   end

   assign load       = board_valid;
   assign eval_valid = (state == S_DONE);

   a_valid_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      eval_valid |=> !eval_valid)
      else $error("eval_sequencer: eval_valid held longer than one cycle");

   a_no_valid_after_clear: assert property (@(posedge clk) disable iff (!rst_n)
      clear_eval |=> !eval_valid)
      else $error("eval_sequencer: eval_valid right after clear_eval");

endmodule

/* logic/latency_counter.sv */
`timescale 1ns/1ps
`include "eval_params.svh"

module latency_counter
(
   input  logic clk,
   input  logic rst_n,
   input  logic load,
   output logic expired
);

   localparam int               CNT_W      = $clog2(`EVAL_LATENCY);
   localparam logic [CNT_W-1:0] LOAD_VALUE = CNT_W'(`EVAL_LATENCY - 1);

   logic [CNT_W-1:0] count;   // Cycles left until the result cycle.

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         count <= '0;
      else if (load)
         count <= LOAD_VALUE;
      else if (count != '0)
         count <= count - 1'b1;   // Holds at zero.
   end

   // Last busy cycle; the result lands on the next one.
   assign expired = (count == CNT_W'(1));

   // Without a load the count only moves down.
   a_count_bounded: assert property (@(posedge clk) disable iff (!rst_n)
      !load |=> (count <= $past(count)) && (count <= LOAD_VALUE))
      else $error("latency_counter: count rose above its loaded value");

endmodule

/* common/eval_pkg.sv */
`include "eval_params.svh"

package eval_pkg;

   typedef enum logic [`PIECE_WIDTH-1:0] {
      EMPTY        = 4'd0,
      WHITE_PAWN   = 4'd1,
      WHITE_KNIGHT = 4'd2,
      WHITE_BISHOP = 4'd3,
      WHITE_ROOK   = 4'd4,
      WHITE_QUEEN  = 4'd5,
      WHITE_KING   = 4'd6,
      BLACK_PAWN   = 4'd9,
      BLACK_KNIGHT = 4'd10,
      BLACK_BISHOP = 4'd11,
      BLACK_ROOK   = 4'd12,
      BLACK_QUEEN  = 4'd13,
      BLACK_KING   = 4'd14
   } piece_e;                                      // Bit 3 marks black.

   typedef piece_e [`BOARD_SQUARES-1:0] board_t;   // Square is rank * 8 + file.

   typedef enum logic [1:0] {
      S_IDLE = 2'd0,
      S_BUSY = 2'd1,
      S_DONE = 2'd2
   } seq_state_e;

   typedef struct packed {
      logic signed [`EVAL_WIDTH-1:0] eval_mg;
      logic signed [`EVAL_WIDTH-1:0] eval_eg;
      logic [`MATERIAL_WIDTH-1:0]    material_white;
      logic [`MATERIAL_WIDTH-1:0]    material_black;
      logic                          insufficient_material;
   } eval_result_t;

   // Value of a piece regardless of colour; kings and unused codes are 0.
   function automatic logic [`MATERIAL_WIDTH-1:0] piece_value(input piece_e piece);
      case (piece_e'({1'b0, piece[2:0]}))
         WHITE_PAWN:   return `MATERIAL_WIDTH'(`VALUE_PAWN);
         WHITE_KNIGHT: return `MATERIAL_WIDTH'(`VALUE_KNIGHT);
         WHITE_BISHOP: return `MATERIAL_WIDTH'(`VALUE_BISHOP);
         WHITE_ROOK:   return `MATERIAL_WIDTH'(`VALUE_ROOK);
         WHITE_QUEEN:  return `MATERIAL_WIDTH'(`VALUE_QUEEN);
         default:      return '0;
      endcase
   endfunction

endpackage

/* common/eval_params.svh */
`ifndef EVAL_PARAMS_SVH
`define EVAL_PARAMS_SVH

// Board geometry.
`define PIECE_WIDTH     4
`define BOARD_SQUARES   64

// Result widths.
`define EVAL_WIDTH      16     // Signed score, positive for white.
`define MATERIAL_WIDTH  16

// Cycles from the board_valid cycle to the eval_valid cycle.
`define EVAL_LATENCY    7

// Piece values in centipawns.
`define VALUE_PAWN      100
`define VALUE_KNIGHT    320
`define VALUE_BISHOP    330
`define VALUE_ROOK      500
`define VALUE_QUEEN     900

`endif
